// File: hdl/video_pkg.sv
// Video scan generator definitions
`default_nettype none

package video_pkg;

    localparam int WORD_W = 16;                     // register and memory word width

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [15:0]       addr_t;              // display memory word address
    typedef logic [7:0]        color_t;             // palette index
    typedef logic [5:0]        reg_num_t;

    // horizontal line: front porch, sync, back porch, visible
    localparam int H_FRONT     = 4;
    localparam int H_SYNC      = 8;
    localparam int H_BACK      = 4;
    localparam int H_VISIBLE   = 32;
    localparam int H_OFFSCREEN = H_FRONT + H_SYNC + H_BACK;
    localparam int H_TOTAL     = H_OFFSCREEN + H_VISIBLE;

    // vertical frame, same order in lines
    localparam int V_FRONT     = 2;
    localparam int V_SYNC      = 2;
    localparam int V_BACK      = 2;
    localparam int V_VISIBLE   = 8;
    localparam int V_OFFSCREEN = V_FRONT + V_SYNC + V_BACK;
    localparam int V_TOTAL     = V_OFFSCREEN + V_VISIBLE;

    localparam int H_W = $clog2(H_TOTAL);
    localparam int V_W = $clog2(V_TOTAL);

    typedef logic [H_W-1:0] hres_t;
    typedef logic [V_W-1:0] vres_t;

    localparam logic HSYNC_ACTIVE = 1'b1;
    localparam logic VSYNC_ACTIVE = 1'b1;

    localparam int FETCH_LEAD  = 4;                 // window opens this early
    localparam int FETCH_TRIM  = 2;                 // and closes this early
    localparam int FETCH_BEGIN = H_OFFSCREEN - FETCH_LEAD;
    localparam int FETCH_END   = H_TOTAL - FETCH_TRIM;

    localparam color_t BORDER_RESET   = 8'h08;      // dark grey
    localparam word_t  LINE_LEN_RESET = 16'd8;

    typedef enum logic [5:0] {
        XR_VID_CTRL     = 6'h00,
        XR_SCANLINE     = 6'h03,
        XR_VID_LEFT     = 6'h04,
        XR_VID_RIGHT    = 6'h05,
        XR_PA_GFX_CTRL  = 6'h10,
        XR_PA_DISP_ADDR = 6'h12,
        XR_PA_LINE_LEN  = 6'h13,
        XR_PA_LINE_ADDR = 6'h16
    } xr_reg_t;

    typedef struct packed {
        hres_t h_count;
        vres_t v_count;
        logic  h_visible;
        logic  v_visible;
        logic  end_of_line;
        logic  end_of_frame;
        logic  end_of_visible;
        logic  hsync;
        logic  vsync;
    } scan_t;

    typedef struct packed {
        color_t border_color;
        hres_t  vid_left;
        hres_t  vid_right;
    } vid_cfg_t;

    typedef struct packed {
        logic   blank;
        color_t colorbase;
        addr_t  start_addr;
        word_t  line_len;
        addr_t  line_set_addr;
        logic   line_set;                           // one cycle after LINE_ADDR write
    } pf_cfg_t;

endpackage

`default_nettype wire

// File: hdl/video_regs.sv
// Video register decode and storage
`default_nettype none
`timescale 1ns/1ps

module video_regs
    import video_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       reg_wr_i,               // register write strobe
    input  wire reg_num_t   reg_num_i,
    input  wire word_t      reg_data_i,
    output vid_cfg_t        vid_cfg_o,
    output pf_cfg_t         pf_cfg_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vid_cfg_o.border_color  <= BORDER_RESET;
            vid_cfg_o.vid_left      <= '0;
            vid_cfg_o.vid_right     <= hres_t'(H_VISIBLE);  // full width window

            pf_cfg_o.blank          <= 1'b1;        // playfield starts blanked
            pf_cfg_o.colorbase      <= '0;
            pf_cfg_o.start_addr     <= '0;
            pf_cfg_o.line_len       <= LINE_LEN_RESET;
            pf_cfg_o.line_set_addr  <= '0;
            pf_cfg_o.line_set       <= 1'b0;
        end else begin
            pf_cfg_o.line_set       <= 1'b0;        // strobe only

            if (reg_wr_i) begin
                case (reg_num_i)
                    XR_VID_CTRL: begin
                        vid_cfg_o.border_color <= reg_data_i[7:0];
                    end
                    XR_VID_LEFT: begin
                        vid_cfg_o.vid_left <= hres_t'(reg_data_i);
                    end
                    XR_VID_RIGHT: begin
                        vid_cfg_o.vid_right <= hres_t'(reg_data_i);
                    end
                    XR_PA_GFX_CTRL: begin
                        // bitmap, depth and repeat bits are not kept
                        pf_cfg_o.colorbase <= reg_data_i[15:8];
                        pf_cfg_o.blank     <= reg_data_i[7];
                    end
                    XR_PA_DISP_ADDR: begin
                        pf_cfg_o.start_addr <= addr_t'(reg_data_i);
                    end
                    XR_PA_LINE_LEN: begin
                        pf_cfg_o.line_len <= reg_data_i;
                    end
                    XR_PA_LINE_ADDR: begin
                        pf_cfg_o.line_set_addr <= addr_t'(reg_data_i);
                        pf_cfg_o.line_set      <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/video_timing.sv
// Raster scan counters
`default_nettype none
`timescale 1ns/1ps

module video_timing
    import video_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset_i,
    output scan_t       scan_o
);

    hres_t  h_next;
    vres_t  v_next;

    // all flags for a given position, so they register together with the count
    function automatic scan_t scan_at(input hres_t h, input vres_t v);
        scan_t s;
        s.h_count        = h;
        s.v_count        = v;
        s.h_visible      = (h >= hres_t'(H_OFFSCREEN));
        s.v_visible      = (v >= vres_t'(V_OFFSCREEN));
        s.end_of_line    = (h == hres_t'(H_TOTAL - 1));
        s.end_of_frame   = s.end_of_line && (v == vres_t'(V_TOTAL - 1));
        s.end_of_visible = s.end_of_line && (v == vres_t'(V_OFFSCREEN + V_VISIBLE - 1));
        if (h >= hres_t'(H_FRONT) && h < hres_t'(H_FRONT + H_SYNC)) begin
            s.hsync = HSYNC_ACTIVE;
        end else begin
            s.hsync = ~HSYNC_ACTIVE;
        end
        if (v >= vres_t'(V_FRONT) && v < vres_t'(V_FRONT + V_SYNC)) begin
            s.vsync = VSYNC_ACTIVE;
        end else begin
            s.vsync = ~VSYNC_ACTIVE;
        end
        return s;
    endfunction

    always_comb begin
        h_next = scan_o.h_count + 1'b1;
        v_next = scan_o.v_count;
        if (scan_o.end_of_line) begin
            h_next = '0;                            // wrap line
            v_next = scan_o.v_count + 1'b1;
            if (scan_o.end_of_frame) begin
                v_next = '0;                        // wrap frame
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            scan_o <= scan_at('0, '0);
        end else begin
            scan_o <= scan_at(h_next, v_next);
        end
    end

endmodule

`default_nettype wire

// File: hdl/fetch_addr_gen.sv
// Display memory fetch address generator
`default_nettype none
`timescale 1ns/1ps

module fetch_addr_gen
    import video_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire scan_t      scan_i,
    input  wire pf_cfg_t    pf_cfg_i,
    output logic            vram_sel_o,             // fetch window, one cycle behind scan
    output addr_t           vram_addr_o
);

    addr_t  line_addr;                              // first word of the coming line
    logic   set_pending;                            // LINE_ADDR written this line
    logic   fetch_next;

    always_comb begin
        fetch_next = scan_i.v_visible && !pf_cfg_i.blank &&
                     (scan_i.h_count >= hres_t'(FETCH_BEGIN)) &&
                     (scan_i.h_count <= hres_t'(FETCH_END));
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_sel_o  <= 1'b0;
            line_addr   <= '0;
            set_pending <= 1'b0;
        end else begin
            vram_sel_o  <= fetch_next;
            set_pending <= (set_pending | pf_cfg_i.line_set) & ~scan_i.end_of_line;

            if (scan_i.end_of_line) begin
                if (set_pending || pf_cfg_i.line_set) begin
                    line_addr <= pf_cfg_i.line_set_addr;    // user address takes the next line
                end else if (scan_i.end_of_frame) begin
                    line_addr <= pf_cfg_i.start_addr;
                end else if (scan_i.v_visible) begin
                    line_addr <= line_addr + addr_t'(pf_cfg_i.line_len);
                end
            end
        end
    end

    // first window cycle carries the line address, then walks up
    always_ff @(posedge clk) begin
        if (vram_sel_o) begin
            vram_addr_o <= vram_addr_o + 1'b1;
        end else begin
            vram_addr_o <= line_addr;
        end
    end

endmodule

`default_nettype wire

// File: hdl/reg_readback.sv
// Register read-back mux
`default_nettype none
`timescale 1ns/1ps

module reg_readback
    import video_pkg::*;
(
    input  wire logic       clk,
    input  wire reg_num_t   reg_num_i,
    input  wire vid_cfg_t   vid_cfg_i,
    input  wire pf_cfg_t    pf_cfg_i,
    input  wire scan_t      scan_i,
    output word_t           reg_data_o              // valid one cycle after reg_num_i
);

    word_t  rd_word;

    always_comb begin
        rd_word = '0;
        case (reg_num_i)
            XR_VID_CTRL:     rd_word = {8'h00, vid_cfg_i.border_color};
            XR_SCANLINE:     rd_word = word_t'(scan_i.v_count);
            XR_VID_LEFT:     rd_word = word_t'(vid_cfg_i.vid_left);
            XR_VID_RIGHT:    rd_word = word_t'(vid_cfg_i.vid_right);
            XR_PA_GFX_CTRL:  rd_word = {pf_cfg_i.colorbase, pf_cfg_i.blank, 7'b0};
            XR_PA_DISP_ADDR: rd_word = word_t'(pf_cfg_i.start_addr);
            XR_PA_LINE_LEN:  rd_word = pf_cfg_i.line_len;
            default:         rd_word = '0;          // LINE_ADDR is write only
        endcase
    end

    always_ff @(posedge clk) begin
        reg_data_o <= rd_word;
    end

endmodule

`default_nettype wire

// File: hdl/video_output.sv
// Colour index and video signal outputs
`default_nettype none
`timescale 1ns/1ps

module video_output
    import video_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire scan_t      scan_i,
    input  wire vid_cfg_t   vid_cfg_i,
    input  wire pf_cfg_t    pf_cfg_i,
    output color_t          colora_index_o,
    output logic            h_blank_o,
    output logic            v_blank_o,
    output logic            hsync_o,
    output logic            vsync_o,
    output logic            dv_de_o,
    output logic            video_intr_o            // vblank pulse
);

    hres_t  h_pos;                                  // position within visible area
    logic   visible;
    logic   in_window;

    always_comb begin
        h_pos     = scan_i.h_count - hres_t'(H_OFFSCREEN);
        visible   = scan_i.h_visible && scan_i.v_visible;
        in_window = (h_pos >= vid_cfg_i.vid_left) && (h_pos < vid_cfg_i.vid_right);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            colora_index_o <= '0;
            h_blank_o      <= 1'b1;
            v_blank_o      <= 1'b1;
            hsync_o        <= ~HSYNC_ACTIVE;
            vsync_o        <= ~VSYNC_ACTIVE;
            dv_de_o        <= 1'b0;
            video_intr_o   <= 1'b0;
        end else begin
            if (!visible) begin
                colora_index_o <= '0;
            end else if (in_window && !pf_cfg_i.blank) begin
                colora_index_o <= pf_cfg_i.colorbase;
            end else begin
                colora_index_o <= vid_cfg_i.border_color;   // border or blanked playfield
            end
            h_blank_o    <= ~scan_i.h_visible;
            v_blank_o    <= ~scan_i.v_visible;
            hsync_o      <= scan_i.hsync;
            vsync_o      <= scan_i.vsync;
            dv_de_o      <= visible;
            video_intr_o <= scan_i.end_of_visible;
        end
    end

endmodule

`default_nettype wire

// File: hdl/video_gen.sv
// Video scan generator top level
`default_nettype none
`timescale 1ns/1ps

module video_gen
    import video_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       reg_wr_i,
    input  wire reg_num_t   reg_num_i,
    input  wire word_t      reg_data_i,
    output word_t           reg_data_o,
    output logic            vram_sel_o,
    output addr_t           vram_addr_o,
    output color_t          colora_index_o,
    output logic            h_blank_o,
    output logic            v_blank_o,
    output logic            hsync_o,
    output logic            vsync_o,
    output logic            dv_de_o,
    output logic            video_intr_o
);

    scan_t      scan;
    vid_cfg_t   vid_cfg;
    pf_cfg_t    pf_cfg;

    video_regs video_regs_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .reg_wr_i   (reg_wr_i),
        .reg_num_i  (reg_num_i),
        .reg_data_i (reg_data_i),
        .vid_cfg_o  (vid_cfg),
        .pf_cfg_o   (pf_cfg)
    );

    video_timing video_timing_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .scan_o     (scan)
    );

    fetch_addr_gen fetch_addr_gen_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .scan_i      (scan),
        .pf_cfg_i    (pf_cfg),
        .vram_sel_o  (vram_sel_o),
        .vram_addr_o (vram_addr_o)
    );

    reg_readback reg_readback_inst (
        .clk        (clk),
        .reg_num_i  (reg_num_i),
        .vid_cfg_i  (vid_cfg),
        .pf_cfg_i   (pf_cfg),
        .scan_i     (scan),
        .reg_data_o (reg_data_o)
    );

    video_output video_output_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .scan_i         (scan),
        .vid_cfg_i      (vid_cfg),
        .pf_cfg_i       (pf_cfg),
        .colora_index_o (colora_index_o),
        .h_blank_o      (h_blank_o),
        .v_blank_o      (v_blank_o),
        .hsync_o        (hsync_o),
        .vsync_o        (vsync_o),
        .dv_de_o        (dv_de_o),
        .video_intr_o   (video_intr_o)
    );

endmodule

`default_nettype wire

// File: testbench/video_gen_tb.sv
// Video scan generator testbench
`default_nettype none
`timescale 1ns/1ps

module video_gen_tb
    import video_pkg::*;
();

    logic       clk;
    logic       reset_i;
    logic       reg_wr_i;
    reg_num_t   reg_num_i;
    word_t      reg_data_i;
    word_t      reg_data_o;
    logic       vram_sel_o;
    addr_t      vram_addr_o;
    color_t     colora_index_o;
    logic       h_blank_o, v_blank_o, hsync_o, vsync_o, dv_de_o, video_intr_o;

    // mirror of the written registers
    color_t     m_border, m_colorbase;
    hres_t      m_left, m_right;
    logic       m_blank;
    addr_t      m_start, fetch_base;
    word_t      m_line_len;
    int         base_line;                          // visible line that fetch_base belongs to

    // compare process state tracked from the output timing
    int         pix_cnt, cur_pix, vis_line, hvis_cnt, vb_lines, hs_count, sel_len, frames;
    logic       seen_vsync, prev_h_blank, prev_v_blank, prev_hsync, prev_vsync, prev_de, prev_sel;
    addr_t      prev_addr;
    logic       pixel_chk, fetch_chk, scan_chk;
    integer     seed;

    reg_num_t   reg_list [9] = '{XR_VID_CTRL, XR_VID_LEFT, XR_VID_RIGHT, XR_PA_GFX_CTRL,
                                 XR_PA_DISP_ADDR, XR_PA_LINE_LEN, XR_PA_LINE_ADDR,
                                 6'h01, 6'h2a};     // last two are unused numbers

    video_gen video_gen_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .reg_wr_i       (reg_wr_i),
        .reg_num_i      (reg_num_i),
        .reg_data_i     (reg_data_i),
        .reg_data_o     (reg_data_o),
        .vram_sel_o     (vram_sel_o),
        .vram_addr_o    (vram_addr_o),
        .colora_index_o (colora_index_o),
        .h_blank_o      (h_blank_o),
        .v_blank_o      (v_blank_o),
        .hsync_o        (hsync_o),
        .vsync_o        (vsync_o),
        .dv_de_o        (dv_de_o),
        .video_intr_o   (video_intr_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                      // 8 ns period
    end

    function automatic word_t expected_read(input reg_num_t num);
        case (num)
            XR_VID_CTRL:     return {8'h00, m_border};
            XR_VID_LEFT:     return word_t'(m_left);
            XR_VID_RIGHT:    return word_t'(m_right);
            XR_PA_GFX_CTRL:  return {m_colorbase, m_blank, 7'b0};
            XR_PA_DISP_ADDR: return word_t'(m_start);
            XR_PA_LINE_LEN:  return m_line_len;
            default:         return '0;             // LINE_ADDR reads as zero
        endcase
    endfunction

    function automatic color_t expected_color(input hres_t pos);
        if (!m_blank && pos >= m_left && pos < m_right) begin
            return m_colorbase;
        end
        return m_border;
    endfunction

    function automatic addr_t expected_first_addr(input int line);
        return fetch_base + addr_t'((line - base_line) * m_line_len);
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_color(input color_t got, input color_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1, "colour mismatch");
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1, "bit mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t ns: no %s arrived in time", $time, what);
        $display("Checks failed");
        $fatal(1, "timeout");
    endtask

    task automatic write_reg(input reg_num_t num, input word_t data);
        @(negedge clk);
        reg_wr_i   = 1'b1;
        reg_num_i  = num;
        reg_data_i = data;
        @(negedge clk);
        reg_wr_i = 1'b0;
        case (num)
            XR_VID_CTRL:     m_border = data[7:0];
            XR_VID_LEFT:     m_left = hres_t'(data);
            XR_VID_RIGHT:    m_right = hres_t'(data);
            XR_PA_GFX_CTRL: begin
                m_colorbase = data[15:8];
                m_blank     = data[7];
            end
            XR_PA_DISP_ADDR: m_start = addr_t'(data);
            XR_PA_LINE_LEN:  m_line_len = data;
            XR_PA_LINE_ADDR: begin
                fetch_base = addr_t'(data);         // takes over from the next line
                base_line  = vis_line + 1;
            end
            default: begin
            end
        endcase
    endtask

    task automatic read_all();
        foreach (reg_list[i]) begin
            @(negedge clk);
            reg_num_i = reg_list[i];
            @(negedge clk);                         // read latency is one cycle
            check_word(reg_data_o, expected_read(reg_list[i]),
                       $sformatf("read-back of register %h", reg_list[i]));
        end
    endtask

    task automatic wait_frames(input int n);
        int target;
        int cycles;
        target = frames + n;
        cycles = 0;
        while (frames < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > (n + 1) * H_TOTAL * V_TOTAL) begin
                report_timeout("frame start");
            end
        end
    endtask

    task automatic wait_visible_line(input int line);
        int cycles;
        cycles = 0;
        while (!(dv_de_o && vis_line == line)) begin
            @(negedge clk);
            cycles++;
            if (cycles > 2 * H_TOTAL * V_TOTAL) begin
                report_timeout("visible line");
            end
        end
    endtask

    // compare process sampling outputs half a cycle after they change
    always @(negedge clk) begin
        if (reset_i) begin
            pix_cnt      = 0;
            vis_line     = 0;
            hvis_cnt     = 0;
            vb_lines     = 0;
            hs_count     = 0;
            sel_len      = 0;
            frames       = 0;
            seen_vsync   = 1'b0;
            prev_h_blank = 1'b1;
            prev_v_blank = 1'b1;
            prev_hsync   = ~HSYNC_ACTIVE;
            prev_vsync   = ~VSYNC_ACTIVE;
            prev_de      = 1'b0;
            prev_sel     = 1'b0;
            prev_addr    = '0;
        end else begin
            cur_pix = dv_de_o ? pix_cnt : 0;
            if (!dv_de_o) begin
                check_color(colora_index_o, 8'h00, "off-screen colour");
            end else if (pixel_chk) begin
                check_color(colora_index_o, expected_color(hres_t'(cur_pix)),
                            $sformatf("colour at pixel %0d", cur_pix));
            end
            check_bit(video_intr_o,
                      dv_de_o && cur_pix == H_VISIBLE - 1 && vis_line == V_VISIBLE - 1,
                      "vblank interrupt");

            if (vsync_o == VSYNC_ACTIVE && prev_vsync != VSYNC_ACTIVE) begin
                if (seen_vsync) begin
                    check_word(word_t'(hs_count), word_t'(V_TOTAL), "hsync pulses per frame");
                end
                hs_count   = 0;
                seen_vsync = 1'b1;
            end
            if (hsync_o == HSYNC_ACTIVE && prev_hsync != HSYNC_ACTIVE) begin
                hs_count++;
            end
            // vsync starts on line V_FRONT, so the first hsync after it is that line
            if (scan_chk && seen_vsync && hsync_o == HSYNC_ACTIVE) begin
                check_word(reg_data_o, word_t'((V_FRONT - 1 + hs_count) % V_TOTAL),
                           "scanline read-back");
            end

            if (!h_blank_o) begin
                hvis_cnt++;
            end
            if (h_blank_o && !prev_h_blank) begin
                check_word(word_t'(hvis_cnt), word_t'(H_VISIBLE), "visible pixels per line");
                hvis_cnt = 0;
            end
            if (!h_blank_o && prev_h_blank && !v_blank_o) begin
                vb_lines++;
            end
            if (v_blank_o && !prev_v_blank) begin
                check_word(word_t'(vb_lines), word_t'(V_VISIBLE), "visible lines per frame");
                vb_lines   = 0;
                frames++;
                fetch_base = m_start;               // new frame restarts at DISP_ADDR
                base_line  = 0;
            end

            if (fetch_chk) begin
                if (m_blank) begin
                    check_bit(vram_sel_o, 1'b0, "fetch on blanked playfield");
                end else if (v_blank_o) begin
                    check_bit(vram_sel_o, 1'b0, "fetch outside visible lines");
                end else if (vram_sel_o && !prev_sel) begin
                    check_addr(vram_addr_o, expected_first_addr(vis_line),
                               $sformatf("first fetch address of line %0d", vis_line));
                end else if (vram_sel_o) begin
                    check_addr(vram_addr_o, prev_addr + 1'b1, "fetch address step");
                end
                if (!vram_sel_o && prev_sel && !m_blank) begin
                    check_word(word_t'(sel_len),
                               word_t'((H_TOTAL - FETCH_TRIM) - (H_OFFSCREEN - FETCH_LEAD) + 1),
                               "fetch window length");
                end
            end
            sel_len = vram_sel_o ? sel_len + 1 : 0;

            if (!dv_de_o && prev_de) begin
                check_word(word_t'(pix_cnt), word_t'(H_VISIBLE), "enabled pixels per line");
            end
            pix_cnt = dv_de_o ? pix_cnt + 1 : 0;
            if (!dv_de_o && prev_de) begin
                vis_line++;
            end
            if (v_blank_o) begin
                vis_line = 0;
            end
            prev_h_blank = h_blank_o;
            prev_v_blank = v_blank_o;
            prev_hsync   = hsync_o;
            prev_vsync   = vsync_o;
            prev_de      = dv_de_o;
            prev_sel     = vram_sel_o;
            prev_addr    = vram_addr_o;
        end
    end

    initial begin : stimulus
        int idx;
        reset_i     = 1'b1;
        reg_wr_i    = 1'b0;
        reg_num_i   = '0;
        reg_data_i  = '0;
        seed        = 32'hbe4;
        pixel_chk   = 1'b0;
        fetch_chk   = 1'b0;
        scan_chk    = 1'b0;
        m_border    = 8'h08;                        // reset values
        m_left      = '0;
        m_right     = hres_t'(H_VISIBLE);
        m_blank     = 1'b1;
        m_colorbase = '0;
        m_start     = '0;
        m_line_len  = LINE_LEN_RESET;
        fetch_base  = '0;
        base_line   = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        read_all();
        repeat (40) begin
            idx = $unsigned($random(seed)) % 9;
            write_reg(reg_list[idx], word_t'($random(seed)));
            read_all();
        end

        @(negedge clk);
        reg_num_i = XR_SCANLINE;
        @(negedge clk);
        scan_chk = 1'b1;
        wait_frames(2);
        scan_chk = 1'b0;
        check_bit(seen_vsync, 1'b1, "vsync pulse seen");
        @(negedge clk);

        write_reg(XR_VID_LEFT, 16'd5);
        write_reg(XR_VID_RIGHT, 16'd27);
        write_reg(XR_VID_CTRL, 16'h0033);
        write_reg(XR_PA_DISP_ADDR, 16'h1200);
        write_reg(XR_PA_LINE_LEN, 16'h0028);
        write_reg(XR_PA_GFX_CTRL, 16'ha500);       // colour base a5 with the playfield shown
        wait_frames(1);
        pixel_chk = 1'b1;
        fetch_chk = 1'b1;
        wait_frames(2);

        // restart the line address in the middle of a frame
        wait_visible_line(3);
        write_reg(XR_PA_LINE_ADDR, word_t'($random(seed)));
        wait_frames(2);

        pixel_chk = 1'b0;
        fetch_chk = 1'b0;
        write_reg(XR_PA_GFX_CTRL, 16'ha580);       // blank the playfield
        repeat (2) @(negedge clk);
        pixel_chk = 1'b1;
        fetch_chk = 1'b1;
        wait_frames(2);

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: video_gen.f
hdl/video_pkg.sv
hdl/video_regs.sv
hdl/video_timing.sv
hdl/fetch_addr_gen.sv
hdl/reg_readback.sv
hdl/video_output.sv
hdl/video_gen.sv
testbench/video_gen_tb.sv
